// ==== Makefile ====
SRCS := $(shell grep '\.sv$$' filelist.f)

obj_dir/Vtile_engine_tb: filelist.f $(SRCS)
	verilator --binary --assert --top-module tile_engine_tb -f filelist.f

run: obj_dir/Vtile_engine_tb
	./obj_dir/Vtile_engine_tb +verilator+error+limit+100 | tee sim.log
	grep -qx 'sim passed' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== bench/tile_engine_properties.sv ====
// Tile engine properties on the reset state, register readback timing and address pipeline
`timescale 1ns/1ns
`default_nettype none

module tile_engine_properties (
  input wire logic                                clk,
  input wire logic                                reset,
  input wire logic                                reg_read,
  input wire logic [tile_pkg::reg_data_width-1:0] reg_rdata,
  input wire logic                                px_valid,
  input wire logic                                addr_valid
);
  int assert_fails = 0;

  // The address pipeline stays quiet through reset
  addr_valid_in_reset: assert property (@(posedge clk) reset |=> !addr_valid)
    else begin
      assert_fails++;
      $error("addr_valid high after a reset cycle");
    end

  // Every request comes out exactly two cycles later and nothing else does
  addr_valid_latency: assert property (@(posedge clk) disable iff (reset)
    (!$past(reset) && !$past(reset, 2)) |-> addr_valid == $past(px_valid, 2))
    else begin
      assert_fails++;
      $error("addr_valid does not follow px_valid by two cycles");
    end

  // Readback data only moves after a read strobe
  rdata_holds: assert property (@(posedge clk) disable iff (reset)
    (!$past(reg_read) && !$past(reset)) |-> $stable(reg_rdata))
    else begin
      assert_fails++;
      $error("reg_rdata changed without a read");
    end

endmodule

bind tile_engine tile_engine_properties props (
  .clk        (clk),
  .reset      (reset),
  .reg_read   (reg_read),
  .reg_rdata  (reg_rdata),
  .px_valid   (px_valid),
  .addr_valid (addr_valid)
);

`default_nettype wire

// ==== bench/tile_engine_tb.sv ====
// Tile engine testbench driving register access and pixel requests against a reference model
`timescale 1ns/1ns
`default_nettype none

module tile_engine_tb;
  import tile_pkg::*;

  localparam int clk_period_ns = 4;
  localparam int reg_accesses = 143;
  localparam int px_requests = 210;
  // Accesses take two cycles and requests one; the factor covers drains and reset
  localparam int watchdog_ns = (2 * reg_accesses + px_requests) * clk_period_ns * 3;

  logic                       clk;
  logic                       reset;
  logic                       reg_write;
  logic                       reg_read;
  logic [reg_addr_width-1:0]  reg_addr;
  logic [reg_data_width-1:0]  reg_wdata;
  logic [reg_data_width-1:0]  reg_rdata;
  logic                       px_valid;
  logic [layer_sel_width-1:0] px_layer;
  logic [coord_width-1:0]     screen_x;
  logic [coord_width-1:0]     screen_y;
  logic                       addr_valid;
  logic                       addr_blank;
  logic [vram_addr_width-1:0] tile_addr;

  int errors = 0;
  int cycle = 0;
  // Host view of every register, indexed by layer * 8 + register
  logic [15:0] shadow [0:31];
  // Requests in flight, with the cycle their address is due
  int          exp_cycle_q[$];
  logic [16:0] exp_data_q[$];
  int          mon_due;
  logic [16:0] mon_exp;

  tile_engine dut (
    .clk        (clk),
    .reset      (reset),
    .reg_write  (reg_write),
    .reg_read   (reg_read),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .px_valid   (px_valid),
    .px_layer   (px_layer),
    .screen_x   (screen_x),
    .screen_y   (screen_y),
    .addr_valid (addr_valid),
    .addr_blank (addr_blank),
    .tile_addr  (tile_addr)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period_ns / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
    $display("sim failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] expected);
    if (got !== expected) begin
      errors++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
    end
  endtask

  function automatic logic [15:0] ctrl_bit(input int pos);
    return 16'(1) << pos;
  endfunction

  function automatic logic [15:0] size_ctrl(input int hsize, input int vsize);
    return 16'(hsize << tile_hsize_lsb) | 16'(vsize << tile_vsize_lsb);
  endfunction

  // Expected {blank, address} for one pixel, from the host's copy of the registers
  function automatic logic [16:0] model_addr(input int layer, input int x, input int y);
    logic [15:0] ctrl0;
    logic [15:0] ctrl1;
    logic [15:0] sx;
    logic [15:0] sy;
    logic [15:0] col;
    logic [15:0] row;
    logic [31:0] base;
    logic [31:0] full;
    logic        blank;
    int          idx;
    idx = layer * num_tile_regs;
    ctrl0 = shadow[idx + tile_ctrl0];
    ctrl1 = shadow[idx + tile_ctrl1];
    sx = 16'(x);
    sy = 16'(y);
    if (ctrl0[enable_scroll]) begin
      sx = sx + shadow[idx + tile_offset_x];
      sy = sy + shadow[idx + tile_offset_y];
    end
    col = sx / (16'd8 << ctrl1[1:0]);
    row = sy / (16'd8 << ctrl1[5:4]);
    blank = !ctrl0[layer_enabled];
    if (col >= 16'd32) begin
      if (ctrl0[enable_wrap_x]) begin
        col = col % 16'd32;
      end else begin
        blank = 1'b1;
      end
    end
    if (row >= 16'd32) begin
      if (ctrl0[enable_wrap_y]) begin
        row = row % 16'd32;
      end else begin
        blank = 1'b1;
      end
    end
    base = {16'b0, shadow[idx + tile_data_offset]};
    if (ctrl0[shift_data_offset]) begin
      base = base * 32'd16;
    end
    full = base + {16'b0, row} * 32'd32 + {16'b0, col};
    if (blank) begin
      return {1'b1, 16'h0};
    end
    return {1'b0, full[15:0]};
  endfunction

  task automatic write_reg(input int layer, input int idx, input logic [15:0] value);
    @(negedge clk);
    reg_write = 1'b1;
    reg_addr = 5'(layer * num_tile_regs + idx);
    reg_wdata = value;
    shadow[layer * num_tile_regs + idx] = value;
    @(negedge clk);
    reg_write = 1'b0;
  endtask

  task automatic read_check(input int addr);
    @(negedge clk);
    reg_read = 1'b1;
    reg_addr = 5'(addr);
    @(negedge clk);
    reg_read = 1'b0;
    check_value("reg_rdata", reg_rdata, shadow[addr]);
  endtask

  task automatic configure_layer(input int layer, input logic [15:0] ctrl0,
                                 input logic [15:0] ctrl1, input logic [15:0] offset);
    write_reg(layer, tile_ctrl0, ctrl0);
    write_reg(layer, tile_ctrl1, ctrl1);
    write_reg(layer, tile_data_offset, offset);
  endtask

  task automatic expect_pixel(input int layer, input int x, input int y,
                              input logic blank, input logic [15:0] addr);
    @(negedge clk);
    px_valid = 1'b1;
    px_layer = 2'(layer);
    screen_x = 10'(x);
    screen_y = 10'(y);
    exp_cycle_q.push_back(cycle + 2);
    exp_data_q.push_back({blank, addr});
  endtask

  task automatic send_pixel(input int layer, input int x, input int y);
    logic [16:0] expected;
    expected = model_addr(layer, x, y);
    expect_pixel(layer, x, y, expected[16], expected[15:0]);
  endtask

  task automatic drain_pipeline();
    int waited;
    waited = 0;
    @(negedge clk);
    px_valid = 1'b0;
    while (exp_cycle_q.size() != 0 && waited < 8) begin
      @(negedge clk);
      waited++;
    end
    if (exp_cycle_q.size() != 0) begin
      errors++;
      $display("Pixel pipeline still held %0d requests after draining", exp_cycle_q.size());
      exp_cycle_q.delete();
      exp_data_q.delete();
    end
  endtask

  // Back to back requests with coordinates drawn from the given ranges
  task automatic random_pixels(input int layer, input int count, input int x_lo,
                               input int x_hi, input int y_lo, input int y_hi);
    int x;
    int y;
    for (int i = 0; i < count; i++) begin
      x = x_lo + int'($urandom % 32'(x_hi - x_lo + 1));
      y = y_lo + int'($urandom % 32'(y_hi - y_lo + 1));
      send_pixel(layer, x, y);
    end
    drain_pipeline();
  endtask

  // Outputs are registered, so they are settled at the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      if (addr_valid) begin
        if (exp_cycle_q.size() == 0) begin
          errors++;
          $display("addr_valid rose at cycle %0d with no request in flight", cycle);
        end else begin
          mon_due = exp_cycle_q.pop_front();
          mon_exp = exp_data_q.pop_front();
          if (mon_due != cycle) begin
            errors++;
            $display("Address came at cycle %0d but was due at cycle %0d", cycle, mon_due);
          end
          check_value("addr_blank", {15'b0, addr_blank}, {15'b0, mon_exp[16]});
          check_value("tile_addr", tile_addr, mon_exp[15:0]);
        end
      end else if (exp_cycle_q.size() != 0 && exp_cycle_q[0] <= cycle) begin
        errors++;
        $display("No address came out for the request due at cycle %0d", exp_cycle_q[0]);
        mon_due = exp_cycle_q.pop_front();
        mon_exp = exp_data_q.pop_front();
      end
    end
  end

  task automatic reg_readback();
    for (int a = 0; a < num_tile_layers * num_tile_regs; a++) begin
      read_check(a);
    end
    for (int a = 0; a < num_tile_layers * num_tile_regs; a++) begin
      write_reg(a / num_tile_regs, a % num_tile_regs, 16'($urandom));
    end
    for (int a = 0; a < num_tile_layers * num_tile_regs; a++) begin
      read_check(a);
    end
  endtask

  task automatic tile_size_sweep();
    int x_hi;
    int y_hi;
    configure_layer(0, ctrl_bit(layer_enabled), 16'h0, 16'($urandom));
    for (int n = 0; n < 4; n++) begin
      write_reg(0, tile_ctrl1, size_ctrl(n, 3 - n));
      // Keep coordinates inside the map so every request gives an address
      x_hi = ((256 << n) > 1024) ? 1023 : (256 << n) - 1;
      y_hi = ((256 << (3 - n)) > 1024) ? 1023 : (256 << (3 - n)) - 1;
      random_pixels(0, 16, 0, x_hi, 0, y_hi);
    end
  endtask

  task automatic scroll_and_shift();
    logic [15:0] scroll_ctrl;
    scroll_ctrl = ctrl_bit(layer_enabled) | ctrl_bit(enable_scroll) |
                  ctrl_bit(enable_wrap_x) | ctrl_bit(enable_wrap_y);
    configure_layer(2, scroll_ctrl, size_ctrl(int'($urandom % 4), int'($urandom % 4)),
                    16'($urandom));
    write_reg(2, tile_offset_x, 16'($urandom));
    write_reg(2, tile_offset_y, 16'($urandom));
    random_pixels(2, 16, 0, 1023, 0, 1023);
    write_reg(2, tile_ctrl0, scroll_ctrl | ctrl_bit(shift_data_offset));
    random_pixels(2, 16, 0, 1023, 0, 1023);
    // An offset of 0x123 becomes 0x1230 once shifted
    configure_layer(2, ctrl_bit(layer_enabled) | ctrl_bit(shift_data_offset), 16'h0, 16'h0123);
    expect_pixel(2, 0, 0, 1'b0, 16'h1230);
    drain_pipeline();
    // Scrolling by 16 and 8 pixels moves the origin two columns right and one row down
    write_reg(2, tile_offset_x, 16'd16);
    write_reg(2, tile_offset_y, 16'd8);
    write_reg(2, tile_ctrl0, ctrl_bit(layer_enabled) | ctrl_bit(enable_scroll) |
              ctrl_bit(shift_data_offset));
    expect_pixel(2, 0, 0, 1'b0, 16'h1252);
    drain_pipeline();
  endtask

  task automatic wrap_and_blank();
    configure_layer(3, ctrl_bit(layer_enabled), 16'h0, 16'h0400);
    // Column 37 lies past the map
    expect_pixel(3, 300, 20, 1'b1, 16'h0);
    drain_pipeline();
    random_pixels(3, 12, 256, 1023, 0, 255);
    write_reg(3, tile_ctrl0, ctrl_bit(layer_enabled) | ctrl_bit(enable_wrap_x));
    // Column 37 wraps to column 5 on row 2
    expect_pixel(3, 300, 20, 1'b0, 16'h0445);
    drain_pipeline();
    random_pixels(3, 12, 256, 1023, 0, 255);
    random_pixels(3, 12, 0, 255, 256, 1023);
    write_reg(3, tile_ctrl0, ctrl_bit(layer_enabled) | ctrl_bit(enable_wrap_y));
    expect_pixel(3, 20, 300, 1'b0, 16'h04a2);
    drain_pipeline();
    random_pixels(3, 12, 0, 255, 256, 1023);
    random_pixels(3, 12, 256, 1023, 0, 255);
  endtask

  task automatic layer_select();
    logic [15:0] ctrl0;
    int          layer;
    // Scroll and wrap are set but the layer itself stays off
    configure_layer(1, ctrl_bit(enable_scroll) | ctrl_bit(enable_wrap_x) |
                    ctrl_bit(enable_wrap_y), size_ctrl(1, 1), 16'($urandom));
    expect_pixel(1, 0, 0, 1'b1, 16'h0);
    random_pixels(1, 16, 0, 1023, 0, 1023);
    for (int l = 0; l < num_tile_layers; l++) begin
      ctrl0 = ctrl_bit(layer_enabled);
      if (l % 2 == 1) begin
        ctrl0 = ctrl0 | ctrl_bit(enable_scroll);
      end
      if (l >= 2) begin
        ctrl0 = ctrl0 | ctrl_bit(shift_data_offset);
      end
      if (l != 3) begin
        ctrl0 = ctrl0 | ctrl_bit(enable_wrap_x) | ctrl_bit(enable_wrap_y);
      end
      configure_layer(l, ctrl0, size_ctrl(l, 3 - l), 16'($urandom));
      write_reg(l, tile_offset_x, 16'($urandom));
      write_reg(l, tile_offset_y, 16'($urandom));
    end
    for (int i = 0; i < 32; i++) begin
      layer = int'($urandom % 4);
      send_pixel(layer, int'($urandom % 1024), int'($urandom % 1024));
    end
    drain_pipeline();
  endtask

  initial begin
    void'($urandom(32'h957d));
    for (int i = 0; i < num_tile_layers * num_tile_regs; i++) begin
      shadow[i] = '0;
    end
    reset = 1'b1;
    reg_write = 1'b0;
    reg_read = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    // Requests held through reset must never reach addr_valid
    px_valid = 1'b1;
    px_layer = '0;
    screen_x = '0;
    screen_y = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    px_valid = 1'b0;

    reg_readback();
    tile_size_sweep();
    scroll_and_shift();
    wrap_and_blank();
    layer_select();
    repeat (2) @(negedge clk);

    $display("Errors: %0d in checks, %0d in assertions", errors, dut.props.assert_fails);
    if (errors == 0 && dut.props.assert_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/tile_addr_gen.sv ====
// Tile map address generator, a two stage pipeline from screen pixel to VRAM address
`timescale 1ns/1ns
`default_nettype none

module tile_addr_gen (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  input  wire logic                                 px_valid,
  input  wire logic [tile_pkg::coord_width-1:0]     screen_x,
  input  wire logic [tile_pkg::coord_width-1:0]     screen_y,
  tile_layer_if.addr_gen                            fields,
  output      logic                                 addr_valid,
  output      logic                                 addr_blank,
  output      logic [tile_pkg::vram_addr_width-1:0] tile_addr
);
  import tile_pkg::*;

  logic [reg_data_width-1:0]    scroll_x;
  logic [reg_data_width-1:0]    scroll_y;

  // Stage 1 state
  logic                         s1_valid;
  logic [reg_data_width-1:0]    s1_x;
  logic [reg_data_width-1:0]    s1_y;
  logic                         s1_enabled;
  logic                         s1_wrap_x;
  logic                         s1_wrap_y;
  tile_size_t                   s1_hsize;
  tile_size_t                   s1_vsize;
  logic [vram_addr_width:0]     s1_data_offset;

  // Stage 2 combinational terms
  logic [2:0]                   x_shift;
  logic [2:0]                   y_shift;
  logic [reg_data_width-1:0]    col_full;
  logic [reg_data_width-1:0]    row_full;
  logic [tile_map_col_bits-1:0] col_idx;
  logic [tile_map_row_bits-1:0] row_idx;
  logic                         blank_x;
  logic                         blank_y;
  logic                         blank;
  logic [vram_addr_width:0]     full_addr;

  // Scroll offsets are added at register width, so the sum wraps at 16 bits
  assign scroll_x = fields.enable_scroll ?
                    reg_data_width'(screen_x) + fields.offset_x : reg_data_width'(screen_x);
  assign scroll_y = fields.enable_scroll ?
                    reg_data_width'(screen_y) + fields.offset_y : reg_data_width'(screen_y);

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= px_valid;
    end
  end

  // Fields are captured with the coordinate so a later register write cannot disturb it
  always_ff @(posedge clk) begin
    s1_x           <= scroll_x;
    s1_y           <= scroll_y;
    s1_enabled     <= fields.layer_enabled;
    s1_wrap_x      <= fields.enable_wrap_x;
    s1_wrap_y      <= fields.enable_wrap_y;
    s1_hsize       <= fields.tile_hsize;
    s1_vsize       <= fields.tile_vsize;
    s1_data_offset <= fields.data_offset;
  end

  // A size code n means tiles of 8 << n pixels
  assign x_shift  = 3'(tile_base_shift) + {1'b0, s1_hsize};
  assign y_shift  = 3'(tile_base_shift) + {1'b0, s1_vsize};
  assign col_full = s1_x >> x_shift;
  assign row_full = s1_y >> y_shift;

  // The map is a power of two wide and tall, so wrapping keeps the low bits
  assign col_idx = col_full[tile_map_col_bits-1:0];
  assign row_idx = row_full[tile_map_row_bits-1:0];
  assign blank_x = (col_full >= reg_data_width'(tile_map_cols)) && !s1_wrap_x;
  assign blank_y = (row_full >= reg_data_width'(tile_map_rows)) && !s1_wrap_y;
  assign blank   = !s1_enabled || blank_x || blank_y;

  assign full_addr = s1_data_offset
                   + (vram_addr_width + 1)'(row_idx * tile_map_cols)
                   + (vram_addr_width + 1)'(col_idx);

  always_ff @(posedge clk) begin
    if (reset) begin
      addr_valid <= 1'b0;
    end else begin
      addr_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    addr_blank <= blank;
    tile_addr  <= blank ? '0 : full_addr[vram_addr_width-1:0];
  end

endmodule

`default_nettype wire

// ==== design/tile_engine.sv ====
// Tile engine front end joining the register bank, field decoder and address generator
`timescale 1ns/1ns
`default_nettype none

module tile_engine (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  // Host register bus
  input  wire logic                                 reg_write,
  input  wire logic                                 reg_read,
  input  wire logic [tile_pkg::reg_addr_width-1:0]  reg_addr,
  input  wire logic [tile_pkg::reg_data_width-1:0]  reg_wdata,
  output      logic [tile_pkg::reg_data_width-1:0]  reg_rdata,
  // Pixel requests in, tile map addresses out two cycles later
  input  wire logic                                 px_valid,
  input  wire logic [tile_pkg::layer_sel_width-1:0] px_layer,
  input  wire logic [tile_pkg::coord_width-1:0]     screen_x,
  input  wire logic [tile_pkg::coord_width-1:0]     screen_y,
  output      logic                                 addr_valid,
  output      logic                                 addr_blank,
  output      logic [tile_pkg::vram_addr_width-1:0] tile_addr
);
  import tile_pkg::*;

  tile_reg_bank_t reg_bank;

  tile_layer_if layer_fields ();

  tile_reg_file u_reg_file (
    .clk       (clk),
    .reset     (reset),
    .reg_write (reg_write),
    .reg_read  (reg_read),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .reg_bank  (reg_bank)
  );

  // The decoder follows px_layer directly, in the request cycle
  tile_reg_decoder u_decoder (
    .current_layer (px_layer),
    .reg_bank      (reg_bank),
    .fields        (layer_fields.decoder)
  );

  tile_addr_gen u_addr_gen (
    .clk        (clk),
    .reset      (reset),
    .px_valid   (px_valid),
    .screen_x   (screen_x),
    .screen_y   (screen_y),
    .fields     (layer_fields.addr_gen),
    .addr_valid (addr_valid),
    .addr_blank (addr_blank),
    .tile_addr  (tile_addr)
  );

endmodule

`default_nettype wire

// ==== design/tile_layer_if.sv ====
// Tile layer field bundle carrying one layer's decoded settings to the address generator
`timescale 1ns/1ns
`default_nettype none

interface tile_layer_if;
  import tile_pkg::*;

  logic                       layer_enabled;
  logic                       enable_scroll;
  logic                       enable_wrap_x;
  logic                       enable_wrap_y;
  tile_size_t                 tile_hsize;
  tile_size_t                 tile_vsize;
  // One bit wider than a VRAM address so a shifted offset keeps its top bit
  logic [vram_addr_width:0]   data_offset;
  logic [reg_data_width-1:0]  offset_x;
  logic [reg_data_width-1:0]  offset_y;

  modport decoder (
    output layer_enabled, enable_scroll, enable_wrap_x, enable_wrap_y,
    output tile_hsize, tile_vsize, data_offset, offset_x, offset_y
  );

  modport addr_gen (
    input layer_enabled, enable_scroll, enable_wrap_x, enable_wrap_y,
    input tile_hsize, tile_vsize, data_offset, offset_x, offset_y
  );

endinterface

`default_nettype wire

// ==== design/tile_pkg.sv ====
// Tile layer package with register map, control bit positions, widths and bank type
`default_nettype none

package tile_pkg;

  // Register bank geometry
  localparam int num_tile_layers = 4;
  localparam int num_tile_regs = 8;
  localparam int reg_data_width = 16;
  localparam int layer_sel_width = $clog2(num_tile_layers);
  localparam int reg_sel_width = $clog2(num_tile_regs);
  // Upper address bits select the layer, lower bits the register
  localparam int reg_addr_width = layer_sel_width + reg_sel_width;

  // Video side widths and tile map geometry
  localparam int vram_addr_width = 16;
  localparam int coord_width = 10;
  localparam int tile_map_cols = 32;
  localparam int tile_map_rows = 32;
  localparam int tile_map_col_bits = $clog2(tile_map_cols);
  localparam int tile_map_row_bits = $clog2(tile_map_rows);
  // Smallest tile is 8 pixels, so size code n shifts by 3 + n
  localparam int tile_base_shift = 3;
  localparam int tile_data_offset_shift = 4;

  // Register indices within one layer; index 7 is reserved storage
  localparam int tile_ctrl0 = 0;
  localparam int tile_ctrl1 = 1;
  localparam int tile_data_offset = 2;
  localparam int tile_nop_value = 3;
  localparam int tile_color_key = 4;
  localparam int tile_offset_x = 5;
  localparam int tile_offset_y = 6;

  // Bit positions in ctrl0
  localparam int layer_enabled = 0;
  localparam int enable_8bit = 1;
  localparam int enable_nop = 2;
  localparam int enable_scroll = 3;
  localparam int enable_transp = 4;
  localparam int enable_alpha = 5;
  localparam int enable_color = 6;
  localparam int enable_wrap_x = 7;
  localparam int enable_wrap_y = 8;
  localparam int enable_flip = 9;
  localparam int shift_data_offset = 10;

  // Tile size fields in ctrl1
  localparam int tile_hsize_lsb = 0;
  localparam int tile_hsize_msb = 1;
  localparam int tile_vsize_lsb = 4;
  localparam int tile_vsize_msb = 5;

  typedef enum logic [1:0] {
    size_8  = 2'd0,
    size_16 = 2'd1,
    size_32 = 2'd2,
    size_64 = 2'd3
  } tile_size_t;

  // All registers of all layers, indexed as bank[layer][register]
  typedef logic [num_tile_layers-1:0][num_tile_regs-1:0][reg_data_width-1:0] tile_reg_bank_t;

endpackage

`default_nettype wire

// ==== design/tile_reg_decoder.sv ====
// Tile register decoder that picks one layer and splits out its control fields
`timescale 1ns/1ns
`default_nettype none

module tile_reg_decoder (
  input wire logic [tile_pkg::layer_sel_width-1:0] current_layer,
  input wire tile_pkg::tile_reg_bank_t             reg_bank,
  tile_layer_if.decoder                            fields
);
  import tile_pkg::*;

  logic [reg_data_width-1:0]  ctrl0;
  logic [reg_data_width-1:0]  ctrl1;
  logic [reg_data_width-1:0]  data_offset_reg;
  logic [vram_addr_width:0]   raw_offset;

  // Registers of the selected layer
  assign ctrl0           = reg_bank[current_layer][tile_ctrl0];
  assign ctrl1           = reg_bank[current_layer][tile_ctrl1];
  assign data_offset_reg = reg_bank[current_layer][tile_data_offset];

  assign fields.layer_enabled = ctrl0[layer_enabled];
  assign fields.enable_scroll = ctrl0[enable_scroll];
  assign fields.enable_wrap_x = ctrl0[enable_wrap_x];
  assign fields.enable_wrap_y = ctrl0[enable_wrap_y];

  assign fields.tile_hsize = tile_size_t'(ctrl1[tile_hsize_msb:tile_hsize_lsb]);
  assign fields.tile_vsize = tile_size_t'(ctrl1[tile_vsize_msb:tile_vsize_lsb]);

  // Shifted offsets lose any bits above the widened offset field
  assign raw_offset = (vram_addr_width + 1)'(data_offset_reg);
  assign fields.data_offset = ctrl0[shift_data_offset] ?
                              (raw_offset << tile_data_offset_shift) : raw_offset;

  assign fields.offset_x = reg_bank[current_layer][tile_offset_x];
  assign fields.offset_y = reg_bank[current_layer][tile_offset_y];

endmodule

`default_nettype wire

// ==== design/tile_reg_file.sv ====
// Tile layer register bank with host strobe writes and registered readback
`timescale 1ns/1ns
`default_nettype none

module tile_reg_file (
  input  wire logic                                clk,
  input  wire logic                                reset,
  input  wire logic                                reg_write,
  input  wire logic                                reg_read,
  input  wire logic [tile_pkg::reg_addr_width-1:0] reg_addr,
  input  wire logic [tile_pkg::reg_data_width-1:0] reg_wdata,
  output      logic [tile_pkg::reg_data_width-1:0] reg_rdata,
  output      tile_pkg::tile_reg_bank_t            reg_bank
);
  import tile_pkg::*;

  logic [layer_sel_width-1:0] addr_layer;
  logic [reg_sel_width-1:0]   addr_reg;

  // Layer in the upper address bits, register index in the lower ones
  assign addr_layer = reg_addr[reg_addr_width-1:reg_sel_width];
  assign addr_reg   = reg_addr[reg_sel_width-1:0];

  // All registers come up as zero, which leaves every layer disabled
  always_ff @(posedge clk) begin
    if (reset) begin
      reg_bank <= '0;
    end else if (reg_write) begin
      reg_bank[addr_layer][addr_reg] <= reg_wdata;
    end
  end

  // A read in the same cycle as a write to the same register sees the old value
  always_ff @(posedge clk) begin
    if (reset) begin
      reg_rdata <= '0;
    end else if (reg_read) begin
      reg_rdata <= reg_bank[addr_layer][addr_reg];
    end
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/tile_pkg.sv
design/tile_layer_if.sv
design/tile_reg_file.sv
design/tile_reg_decoder.sv
design/tile_addr_gen.sv
design/tile_engine.sv
bench/tile_engine_properties.sv
bench/tile_engine_tb.sv
